// File: list.f
+incdir+src
src/spi_pkg.sv
src/spi_sclk_gen.sv
src/spi_master.sv
src/spi_slave.sv
src/spi_loopback.sv
sim/spi_loopback_tb.sv

// File: sim/spi_loopback_stim.txt
// one transfer per line, hex: master_byte slave_byte clk_div, then ack_class in decimal
// ack_class 0 prompt, 1 random rd_ack delay, 2 rd_ack withheld past the next frame
a5 5a 02 0
3c c3 03 1
ff 00 02 0
00 ff 04 0
81 7e 05 1
12 34 02 2
56 78 03 0
9a bc 02 0
de f0 07 1
01 80 02 2
fe 7f 04 1
55 aa 02 0
c6 39 09 1
e7 18 03 2
24 db 02 0
6b 94 06 1
f0 0f 02 0

// File: sim/spi_loopback_tb.sv
/* testbench for the SPI loopback top level
   plays each transfer of sim/spi_loopback_stim.txt through both handshakes and checks
   the bytes, overrun, frame length and bus idle levels, compiled from list.f */

`timescale 1ns/10ps
`default_nettype none

`include "spi_consts.svh"

module spi_loopback_tb import spi_pkg::*; ();

	localparam bit CPOL      = `SPI_CPOL_DEF;
	localparam bit CPHA      = `SPI_CPHA_DEF;
	localparam int W         = `SPI_DATA_W;
	localparam int MAX_LINES = 64;

	logic         sys_clk;
	logic         rst_n;
	logic [7:0]   clk_div;
	logic         wr_req;
	spi_xfer_t    tx_payload;
	logic         wr_ack;
	spi_xfer_t    rx_payload;
	logic [W-1:0] slave_tx;
	logic         rd_req;
	logic         rd_ack;
	spi_rx_t      rx_out;
	spi_bus_t     bus;

	logic [W-1:0] m_byte [0:MAX_LINES-1];  // master sends, slave should see
	logic [W-1:0] s_byte [0:MAX_LINES-1];  // slave replies, master should see
	logic [7:0]   div_val [0:MAX_LINES-1];
	int           ack_class [0:MAX_LINES-1];
	int           n_lines;
	int           err_cnt;
	int           done_cnt;
	int           cycle_cnt = 0;
	int           cycle_limit;
	int           low_cnt;                 // cs low cycles this frame
	int           high_cnt;                // cs high cycles since last frame
	logic         cs_last;
	logic [7:0]   frame_div;               // divider of the frame in flight
	logic [15:0]  lfsr;
	int           i;

	spi_loopback #(
		.CPOL(CPOL),
		.CPHA(CPHA)
	) uut (
		.sys_clk    (sys_clk),
		.rst_n      (rst_n),
		.clk_div    (clk_div),
		.wr_req     (wr_req),
		.tx_payload (tx_payload),
		.wr_ack     (wr_ack),
		.rx_payload (rx_payload),
		.slave_tx   (slave_tx),
		.rd_req     (rd_req),
		.rd_ack     (rd_ack),
		.rx_out     (rx_out),
		.bus        (bus)
	);

	always #4 sys_clk = ~sys_clk; // 8 ns period

	task report_mismatch(input string name, input logic [31:0] exp_val,
			input logic [31:0] act_val);
		err_cnt = err_cnt + 1;
		$display("Fail at %0t: %s expected %0h, got %0h", $time, name, exp_val, act_val);
	endtask

	task report_failure(input string what);
		err_cnt = err_cnt + 1;
		$display("Error at %0t: %s", $time, what);
	endtask

	// galois form, taps 16,14,13,11
	function logic [15:0] lfsr_step(input logic [15:0] s);
		if (s[0])
			lfsr_step = (s >> 1) ^ 16'hB400;
		else
			lfsr_step = s >> 1;
	endfunction

	task take_bits(input int n, output int val);
		int k;
		val = 0;
		for (k = 0; k < n; k++) begin
			lfsr = lfsr_step(lfsr); // one step per bit
			val  = (val << 1) | lfsr[0];
		end
	endtask

	task load_stim();
		int              fd;
		int              cls;
		logic [8*96-1:0] text;
		logic [7:0]      a;
		logic [7:0]      b;
		logic [7:0]      c;
		n_lines = 0;
		fd = $fopen("sim/spi_loopback_stim.txt", "r");
		if (fd == 0) begin
			report_failure("stimulus file sim/spi_loopback_stim.txt could not be opened");
		end else begin
			while (n_lines < MAX_LINES && $fgets(text, fd) != 0) begin
				if ($sscanf(text, "%h %h %h %d", a, b, c, cls) == 4) begin // comments skip
					m_byte[n_lines]    = a;
					s_byte[n_lines]    = b;
					div_val[n_lines]   = c;
					ack_class[n_lines] = cls;
					n_lines = n_lines + 1;
				end
			end
			$fclose(fd);
			if (n_lines == 0)
				report_failure("stimulus file holds no transfers");
		end
	endtask

	task run_line(input int k);
		int       hold;
		int       dly;
		spi_rx_t  held;
		logic     exp_ovr;
		exp_ovr = 1'b0;
		if (k > 0)
			exp_ovr = (ack_class[k-1] == 2); // previous byte left unacked
		@(posedge sys_clk);
		tx_payload.data <= m_byte[k];
		slave_tx        <= s_byte[k];
		clk_div         <= div_val[k];
		frame_div       <= div_val[k];
		@(posedge sys_clk);
		wr_req <= 1'b1;
		@(posedge sys_clk);
		while (!wr_ack)
			@(posedge sys_clk);
		if (rx_payload.data !== s_byte[k])
			report_mismatch("rx_payload.data", s_byte[k], rx_payload.data);
		take_bits(3, hold);
		repeat (hold) begin                  // wr_ack must wait for us
			@(posedge sys_clk);
			if (wr_ack !== 1'b1)
				report_failure("wr_ack dropped while wr_req was still high");
		end
		wr_req <= 1'b0;
		@(posedge sys_clk);
		while (wr_ack)
			@(posedge sys_clk);
		while (!rd_req)                      // may still be up from an unacked byte
			@(posedge sys_clk);
		if (rx_out.data !== m_byte[k])
			report_mismatch("rx_out.data", m_byte[k], rx_out.data);
		if (rx_out.overrun !== exp_ovr)
			report_mismatch("rx_out.overrun", exp_ovr, rx_out.overrun);
		if (ack_class[k] != 2) begin         // class 2 leaves rd_req hanging
			held = rx_out;
			if (ack_class[k] == 1) begin
				take_bits(3, dly);
				repeat (dly) begin
					@(posedge sys_clk);
					if (rd_req !== 1'b1 || rx_out !== held)
						report_failure("rx_out or rd_req changed before rd_ack");
				end
			end
			rd_ack <= 1'b1;
			@(posedge sys_clk);
			while (rd_req)
				@(posedge sys_clk);
			rd_ack <= 1'b0;
		end
		done_cnt = done_cnt + 1;
	endtask

	// bus watcher, frame length and idle levels
	always @(posedge sys_clk) begin
		if (rst_n) begin
			if (bus.cs && bus.sclk !== CPOL)
				report_failure("sclk left its idle level while cs was high");
			if (cs_last && !bus.cs && wr_ack)
				report_failure("cs fell before wr_ack returned low");
			if (bus.cs) begin
				high_cnt = high_cnt + 1;     // slave sees cs a few cycles late
				if (high_cnt > `SPI_SYNC_STAGES + 1 && bus.miso !== 1'b1)
					report_mismatch("bus.miso", 1, bus.miso);
			end else begin
				high_cnt = 0;
			end
			if (!bus.cs) begin
				low_cnt = low_cnt + 1;
			end else if (low_cnt != 0) begin
				if (low_cnt != 18 * (int'(frame_div) + 1))
					report_mismatch("cs low cycles", 18 * (int'(frame_div) + 1), low_cnt);
				low_cnt = 0;
			end
			cs_last = bus.cs;
		end
	end

	always @(posedge sys_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit) begin
			$display("Error at %0t: run stuck, stopped after %0d cycles", $time, cycle_cnt);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	initial begin
		sys_clk    = 1'b0;
		rst_n      = 1'b0;
		clk_div    = '0;
		wr_req     = 1'b0;
		tx_payload = '0;
		slave_tx   = '0;
		rd_ack     = 1'b0;
		err_cnt    = 0;
		done_cnt   = 0;
		low_cnt    = 0;
		high_cnt   = 0;
		cs_last    = 1'b1;
		frame_div  = '0;
		lfsr       = 16'd26036;
		load_stim();
		cycle_limit = 200;
		for (i = 0; i < n_lines; i++)
			cycle_limit = cycle_limit + 18 * (int'(div_val[i]) + 1) + 40;
		repeat (3) @(posedge sys_clk);
		rst_n <= 1'b1;
		@(posedge sys_clk);
		if (bus.cs !== 1'b1)
			report_mismatch("bus.cs", 1, bus.cs);
		if (bus.sclk !== CPOL)
			report_mismatch("bus.sclk", CPOL, bus.sclk);
		if (wr_ack !== 1'b0)
			report_mismatch("wr_ack", 0, wr_ack);
		if (rd_req !== 1'b0)
			report_mismatch("rd_req", 0, rd_req);
		for (i = 0; i < n_lines; i++)
			run_line(i);
		repeat (4) @(posedge sys_clk);
		$display("transfers %0d of %0d, errors %0d", done_cnt, n_lines, err_cnt);
		if (err_cnt == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: src/spi_consts.svh
/* constants shared by the SPI loopback design
   pull in with `include wherever a width or a default mode is needed */

`ifndef SPI_CONSTS_SVH
`define SPI_CONSTS_SVH

// bits per frame
`define SPI_DATA_W 8

// idle level of sclk
`define SPI_CPOL_DEF 1'b1

// 1 = sample on trailing edge, shift on leading
`define SPI_CPHA_DEF 1'b1

// flops in the slave input synchronizer
`define SPI_SYNC_STAGES 2

`endif

// File: src/spi_loopback.sv
/* SPI master and slave joined on one bus, with the bus brought out for observation
   the master takes bytes via wr_req/wr_ack, the slave hands them out via rd_req/rd_ack */

`timescale 1ns/10ps
`default_nettype none

`include "spi_consts.svh"

module spi_loopback import spi_pkg::*; #(
	parameter bit CPOL = `SPI_CPOL_DEF,
	parameter bit CPHA = `SPI_CPHA_DEF
) (
	input  logic                   sys_clk,
	input  logic                   rst_n,
	input  logic [7:0]             clk_div,
	input  logic                   wr_req,
	input  spi_xfer_t              tx_payload,
	output logic                   wr_ack,
	output spi_xfer_t              rx_payload,
	input  logic [`SPI_DATA_W-1:0] slave_tx, // slave reply byte
	output logic                   rd_req,
	input  logic                   rd_ack,
	output spi_rx_t                rx_out,
	output spi_bus_t               bus       // observation copy of the bus
);

	logic cs;   // master driven
	logic sclk;
	logic mosi;
	logic miso; // slave driven

	spi_master #(
		.CPOL(CPOL),
		.CPHA(CPHA)
	) ins_spi_master (
		.sys_clk    (sys_clk),
		.rst_n      (rst_n),
		.clk_div    (clk_div),
		.wr_req     (wr_req),
		.tx_payload (tx_payload),
		.wr_ack     (wr_ack),
		.rx_payload (rx_payload),
		.cs         (cs),
		.sclk       (sclk),
		.mosi       (mosi),
		.miso       (miso)
	);

	spi_slave #(
		.CPOL(CPOL),
		.CPHA(CPHA)
	) ins_spi_slave (
		.sys_clk (sys_clk),
		.rst_n   (rst_n),
		.cs      (cs),
		.sclk    (sclk),
		.mosi    (mosi),
		.miso    (miso),
		.data_tx (slave_tx),
		.rd_req  (rd_req),
		.rd_ack  (rd_ack),
		.rx_out  (rx_out)
	);

	assign bus = '{cs: cs, sclk: sclk, mosi: mosi, miso: miso};

endmodule

`default_nettype wire

// File: src/spi_master.sv
/* SPI master with automatic per-byte chip select
   a wr_req/wr_ack four-phase handshake starts one frame and returns the byte read from miso */

`timescale 1ns/10ps
`default_nettype none

`include "spi_consts.svh"

module spi_master import spi_pkg::*; #(
	parameter bit CPOL = `SPI_CPOL_DEF,
	parameter bit CPHA = `SPI_CPHA_DEF
) (
	input  logic       sys_clk,
	input  logic       rst_n,
	input  logic [7:0] clk_div,    // taken at frame start only
	input  logic       wr_req,
	input  spi_xfer_t  tx_payload,
	output logic       wr_ack,
	output spi_xfer_t  rx_payload,
	output logic       cs,
	output logic       sclk,
	output logic       mosi,
	input  logic       miso
);

	localparam int W     = `SPI_DATA_W;
	localparam int EDGES = 2 * W;            // sclk edges per frame
	localparam int EW    = $clog2(EDGES);

	typedef enum logic [2:0] {
		ST_IDLE,  // cs high, waiting for wr_req
		ST_SETUP, // cs low, before first sclk edge
		ST_SHIFT, // clocking bits
		ST_HOLD,  // cs still low after the last edge
		ST_ACK    // wr_ack up until wr_req drops
	} state_t;

	state_t          state;
	logic [7:0]      div_q;       // divider for this frame
	logic [EW-1:0]   edge_cnt;    // sclk edges seen so far
	logic [8:0]      hold_cnt;    // cycles spent in hold
	logic [W-1:0]    sreg;        // tx bits out the top, rx bits in the bottom
	logic            run;
	logic            lead_edge;
	logic            trail_edge;
	logic            any_edge;
	logic            last_edge;
	logic            sample_edge;
	logic            drive_edge;
	logic            start;
	logic            frame_end;

	assign any_edge    = lead_edge | trail_edge;
	assign last_edge   = any_edge && (edge_cnt == EW'(EDGES - 1));
	assign sample_edge = CPHA ? trail_edge : lead_edge;
	assign drive_edge  = CPHA ? lead_edge : trail_edge;
	assign start       = (state == ST_IDLE) && wr_req;
	assign frame_end   = (state == ST_HOLD) && (hold_cnt == {div_q, 1'b0}); // two half-periods
	// drop run on the last strobe so a fast divider cannot squeeze in an extra edge
	assign run = ((state == ST_SETUP) || (state == ST_SHIFT)) && !last_edge;

	spi_sclk_gen #(
		.CPOL(CPOL)
	) ins_sclk_gen (
		.sys_clk    (sys_clk),
		.rst_n      (rst_n),
		.run        (run),
		.clk_div    (div_q),
		.sclk       (sclk),
		.lead_edge  (lead_edge),
		.trail_edge (trail_edge)
	);

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			state    <= ST_IDLE;
			cs       <= 1'b1;
			wr_ack   <= 1'b0;
			edge_cnt <= '0;
			hold_cnt <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (start) begin
						cs       <= 1'b0; // sclk gen starts same cycle
						edge_cnt <= '0;
						state    <= ST_SETUP;
					end
				end
				ST_SETUP: begin
					if (any_edge) begin
						edge_cnt <= edge_cnt + 1'b1;
						state    <= ST_SHIFT;
					end
				end
				ST_SHIFT: begin
					if (last_edge) begin
						hold_cnt <= '0;
						state    <= ST_HOLD;
					end else if (any_edge) begin
						edge_cnt <= edge_cnt + 1'b1;
					end
				end
				ST_HOLD: begin
					if (frame_end) begin
						cs     <= 1'b1;
						wr_ack <= 1'b1; // rises with cs
						state  <= ST_ACK;
					end else begin
						hold_cnt <= hold_cnt + 9'd1;
					end
				end
				ST_ACK: begin
					if (!wr_req) begin
						wr_ack <= 1'b0;
						state  <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!rst_n)
			mosi <= 1'b1;
		else if (start)
			mosi <= tx_payload.data[W-1]; // msb ready before first edge
		else if (drive_edge)
			mosi <= sreg[W-1];
		else if (frame_end)
			mosi <= 1'b1;                 // idle high between frames
	end

	always_ff @(posedge sys_clk) begin
		if (start) begin
			sreg  <= tx_payload.data;
			div_q <= clk_div;
		end else if (sample_edge) begin
			sreg <= {sreg[W-2:0], miso};
		end
		if (frame_end)
			rx_payload.data <= sreg; // full rx byte by now
	end

endmodule

`default_nettype wire

// File: src/spi_pkg.sv
/* bus and payload types shared by master, slave and top level
   import with spi_pkg::* in the module header */

`default_nettype none

`include "spi_consts.svh"

package spi_pkg;

	typedef struct packed {
		logic cs;   // chip select, active low
		logic sclk; // serial clock
		logic mosi; // master to slave
		logic miso; // slave to master
	} spi_bus_t;

	// request payload to the master, and the byte it returns
	typedef struct packed {
		logic [`SPI_DATA_W-1:0] data;
	} spi_xfer_t;

	// byte handed out by the slave
	typedef struct packed {
		logic                   overrun; // previous byte never acked
		logic [`SPI_DATA_W-1:0] data;
	} spi_rx_t;

endpackage

`default_nettype wire

// File: src/spi_sclk_gen.sv
/* serial clock divider for the SPI master
   toggles sclk every clk_div+1 cycles while run is high, with one-cycle edge strobes */

`timescale 1ns/10ps
`default_nettype none

`include "spi_consts.svh"

module spi_sclk_gen #(
	parameter bit CPOL = `SPI_CPOL_DEF
) (
	input  logic       sys_clk,
	input  logic       rst_n,
	input  logic       run,        // high for the active part of a frame
	input  logic [7:0] clk_div,    // half-period minus one
	output logic       sclk,
	output logic       lead_edge,  // sclk just left CPOL
	output logic       trail_edge  // sclk just returned to CPOL
);

	logic [7:0] cnt;       // cycles into current half-period
	logic       half_done; // last cycle of the half-period

	assign half_done = (cnt == clk_div);

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			cnt        <= '0;
			sclk       <= CPOL;
			lead_edge  <= 1'b0;
			trail_edge <= 1'b0;
		end else if (!run) begin
			cnt        <= '0;   // restart cleanly next frame
			sclk       <= CPOL; // park at idle level
			lead_edge  <= 1'b0;
			trail_edge <= 1'b0;
		end else begin
			lead_edge  <= half_done && (sclk == CPOL);
			trail_edge <= half_done && (sclk != CPOL);
			if (half_done) begin
				cnt  <= '0;
				sclk <= ~sclk; // edge lands with its strobe
			end else begin
				cnt <= cnt + 8'd1;
			end
		end
	end

endmodule

`default_nettype wire

// File: src/spi_slave.sv
/* SPI slave that oversamples the bus in sys_clk
   each received byte goes out through rd_req/rd_ack, overrun marks a byte that replaced
   one still unacknowledged, the reply byte comes from data_tx at chip select fall */

`timescale 1ns/10ps
`default_nettype none

`include "spi_consts.svh"

module spi_slave import spi_pkg::*; #(
	parameter bit CPOL = `SPI_CPOL_DEF,
	parameter bit CPHA = `SPI_CPHA_DEF
) (
	input  logic                   sys_clk,
	input  logic                   rst_n,
	input  logic                   cs,
	input  logic                   sclk,
	input  logic                   mosi,
	output logic                   miso,
	input  logic [`SPI_DATA_W-1:0] data_tx, // reply byte
	output logic                   rd_req,
	input  logic                   rd_ack,
	output spi_rx_t                rx_out
);

	localparam int W  = `SPI_DATA_W;
	localparam int NS = `SPI_SYNC_STAGES;
	localparam int BW = $clog2(W);

	logic [NS-1:0] cs_sync;
	logic [NS-1:0] sclk_sync;
	logic [NS-1:0] mosi_sync;
	logic          cs_s;      // synchronized copies
	logic          sclk_s;
	logic          mosi_s;
	logic          cs_prev;   // one more stage for edge detect
	logic          sclk_prev;
	logic          cs_fall;
	logic          lead_edge;
	logic          trail_edge;
	logic          sample_edge;
	logic          drive_edge;
	logic [W-1:0]  sreg;      // reply out the top, mosi in the bottom
	logic [BW-1:0] bit_cnt;   // samples taken this frame
	logic [W-1:0]  rx_byte;
	logic          byte_done;

	assign cs_s   = cs_sync[NS-1];
	assign sclk_s = sclk_sync[NS-1];
	assign mosi_s = mosi_sync[NS-1];

	assign cs_fall     = cs_prev && !cs_s;
	assign lead_edge   = !cs_s && (sclk_prev == CPOL) && (sclk_s != CPOL);
	assign trail_edge  = !cs_s && (sclk_prev != CPOL) && (sclk_s == CPOL);
	assign sample_edge = CPHA ? trail_edge : lead_edge;
	assign drive_edge  = CPHA ? lead_edge : trail_edge;
	assign rx_byte     = {sreg[W-2:0], mosi_s};
	assign byte_done   = sample_edge && (bit_cnt == BW'(W - 1));

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			cs_sync   <= '1;          // idle bus, no false edge out of reset
			sclk_sync <= {NS{CPOL}};
			cs_prev   <= 1'b1;
			sclk_prev <= CPOL;
		end else begin
			cs_sync   <= {cs_sync[NS-2:0], cs};
			sclk_sync <= {sclk_sync[NS-2:0], sclk};
			cs_prev   <= cs_s;
			sclk_prev <= sclk_s;
		end
		mosi_sync <= {mosi_sync[NS-2:0], mosi}; // data only
	end

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			miso    <= 1'b1;
			bit_cnt <= '0;
		end else if (cs_s) begin
			miso    <= 1'b1;         // released while deselected
			bit_cnt <= '0;
		end else if (cs_fall) begin
			miso    <= data_tx[W-1]; // msb for a cpha=0 first sample
			bit_cnt <= '0;
		end else begin
			if (drive_edge)
				miso <= sreg[W-1];
			if (sample_edge)
				bit_cnt <= bit_cnt + 1'b1; // wraps after the last bit
		end
	end

	always_ff @(posedge sys_clk) begin
		if (cs_fall)
			sreg <= data_tx;
		else if (sample_edge)
			sreg <= rx_byte;
	end

	always_ff @(posedge sys_clk) begin
		if (!rst_n)
			rd_req <= 1'b0;
		else if (byte_done)
			rd_req <= 1'b1;
		else if (rd_req && rd_ack)
			rd_req <= 1'b0; // consumer took it
	end

	always_ff @(posedge sys_clk) begin
		if (byte_done) begin
			rx_out.data    <= rx_byte;
			rx_out.overrun <= rd_req || rd_ack; // old handoff still open
		end
	end

endmodule

`default_nettype wire
